// ==== src/dcache_wb_pkg.sv ====
package dcache_wb_pkg;

    // front-end address and data geometry
    localparam int FE_ADDR_W   = 32;
    localparam int WORD_W      = 32;   // cache word, also the AXI data width
    localparam int NBYTES      = WORD_W / 8;
    localparam int BYTE_OFF_W  = 2;
    localparam int WORD_OFF_W  = 2;    // four words per line
    localparam int LINE_W      = WORD_W * (2 ** WORD_OFF_W);
    localparam int LINE_ADDR_W = FE_ADDR_W - BYTE_OFF_W - WORD_OFF_W;

    // beats per burst, log2
    localparam int LINE2MEM_W = 2;

    // fixed AXI write attributes
    localparam int                  AXI_ID_W       = 1;
    localparam logic [AXI_ID_W-1:0] AXI_ID         = '0;
    localparam logic [7:0]          AXI_LEN        = 8'((2 ** LINE2MEM_W) - 1);
    localparam logic [2:0]          AXI_SIZE       = 3'd2;  // 4 bytes per beat
    localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
    localparam logic [3:0]          AXI_CACHE      = 4'b0011;
    localparam logic [1:0]          RESP_OKAY      = 2'b00;

    // evicted line buffering
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

    // statistics counters
    localparam int CNT_W = 16;

    // write channel FSM encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ADDR  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;
    localparam logic [1:0] ST_RESP  = 2'd3;

endpackage

// ==== src/evict_queue.sv ====
`timescale 1ns/1ns

module evict_queue
    import dcache_wb_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // from the cache core
    input  logic                   evict_valid,
    input  logic [LINE_ADDR_W-1:0] evict_addr,
    input  logic [LINE_W-1:0]      evict_line,
    output logic                   evict_ready,

    // towards the write channel
    output logic                   valid,
    output logic [LINE_ADDR_W-1:0] addr,
    output logic [LINE_W-1:0]      wdata,
    input  logic                   ready
);

    logic [LINE_ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
    logic [LINE_W-1:0]      line_mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;   // one extra bit to tell full from empty

    logic push;
    logic pop;

    assign evict_ready = (count != (QUEUE_PTR_W+1)'(QUEUE_DEPTH));
    assign valid       = (count != '0);

    assign push = evict_valid & evict_ready;
    assign pop  = valid & ready;

    // head entry, held until the write channel reports success
    assign addr  = addr_mem[rd_ptr];
    assign wdata = line_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= evict_addr;
            line_mem[wr_ptr] <= evict_line;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

// ==== src/write_channel.sv ====
`timescale 1ns/1ns

module write_channel
    import dcache_wb_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // head of the evict queue
    input  logic                   valid,
    input  logic [LINE_ADDR_W-1:0] addr,
    input  logic [LINE_W-1:0]      wdata,
    output logic                   ready,

    // AW channel
    output logic                   awvalid,
    output logic [FE_ADDR_W-1:0]   awaddr,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,
    output logic [0:0]             awlock,
    output logic [3:0]             awcache,
    output logic [2:0]             awprot,
    output logic [3:0]             awqos,
    output logic [AXI_ID_W-1:0]    awid,
    input  logic                   awready,

    // W channel
    output logic                   wvalid,
    output logic [WORD_W-1:0]      wdata_axi,
    output logic [NBYTES-1:0]      wstrb,
    output logic                   wlast,
    input  logic                   wready,

    // B channel
    input  logic                   bvalid,
    input  logic [1:0]             bresp,
    output logic                   bready
);

    logic [1:0]            state;
    logic [LINE2MEM_W-1:0] word_cnt;
    logic                  last_word;
    logic                  resp_ok;

    // fixed burst attributes
    assign awid    = AXI_ID;
    assign awlen   = AXI_LEN;
    assign awsize  = AXI_SIZE;
    assign awburst = AXI_BURST_INCR;
    assign awlock  = 1'b0;
    assign awcache = AXI_CACHE;
    assign awprot  = 3'd0;
    assign awqos   = 4'd0;

    // line aligned burst start, word and byte offsets zero
    assign awaddr = {addr, {(WORD_OFF_W + BYTE_OFF_W){1'b0}}};

    // full-line writes only
    assign wstrb     = {NBYTES{1'b1}};
    assign wdata_axi = wdata[word_cnt*WORD_W +: WORD_W];   // word 0 goes first

    assign last_word = &word_cnt;
    assign resp_ok   = (bresp == RESP_OKAY);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (valid) begin
                        state <= ST_ADDR;
                    end
                end

                ST_ADDR: begin
                    word_cnt <= '0;   // fresh count for every burst, retries too
                    if (awready) begin
                        state <= ST_WRITE;
                    end
                end

                ST_WRITE: begin
                    if (wready) begin
                        if (last_word) begin
                            state <= ST_RESP;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end

                ST_RESP: begin
                    // an error keeps the line and sends the whole burst again
                    if (bvalid) begin
                        state <= resp_ok ? ST_IDLE : ST_ADDR;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // handshake outputs decoded from the state register
    always_comb begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        ready   = 1'b0;
        case (state)
            ST_ADDR:  awvalid = 1'b1;
            ST_WRITE: wvalid  = 1'b1;
            ST_RESP: begin
                bready = 1'b1;
                ready  = bvalid & resp_ok;   // pops the queue head
            end
            default: ;
        endcase
    end

    assign wlast = wvalid & last_word;

endmodule

// ==== src/write_resp_monitor.sv ====
`timescale 1ns/1ns

module write_resp_monitor
    import dcache_wb_pkg::*;
(
    input  logic             clk,
    input  logic             reset,

    // observed B channel
    input  logic             bvalid,
    input  logic             bready,
    input  logic [1:0]       bresp,

    // completion and error statistics for the cache core
    output logic             line_done,
    output logic [CNT_W-1:0] lines_written,
    output logic [CNT_W-1:0] retry_count
);

    logic b_hs;
    logic b_ok;
    logic b_err;

    assign b_hs  = bvalid & bready;
    assign b_ok  = b_hs & (bresp == RESP_OKAY);
    assign b_err = b_hs & (bresp != RESP_OKAY);   // SLVERR or DECERR

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            line_done     <= 1'b0;
            lines_written <= '0;
            retry_count   <= '0;
        end else begin
            line_done <= b_ok;   // one cycle after the OKAY handshake
            if (b_ok) begin
                lines_written <= lines_written + 1'b1;
            end
            if (b_err) begin
                retry_count <= retry_count + 1'b1;
            end
        end
    end

endmodule

// ==== src/dcache_write_back.sv ====
`timescale 1ns/1ns

module dcache_write_back
    import dcache_wb_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // evicted lines from the cache core
    input  logic                   evict_valid,
    input  logic [LINE_ADDR_W-1:0] evict_addr,
    input  logic [LINE_W-1:0]      evict_line,
    output logic                   evict_ready,

    // statistics
    output logic                   line_done,
    output logic [CNT_W-1:0]       lines_written,
    output logic [CNT_W-1:0]       retry_count,

    // AXI4 write address
    output logic                   axi_awvalid,
    output logic [FE_ADDR_W-1:0]   axi_awaddr,
    output logic [7:0]             axi_awlen,
    output logic [2:0]             axi_awsize,
    output logic [1:0]             axi_awburst,
    output logic [0:0]             axi_awlock,
    output logic [3:0]             axi_awcache,
    output logic [2:0]             axi_awprot,
    output logic [3:0]             axi_awqos,
    output logic [AXI_ID_W-1:0]    axi_awid,
    input  logic                   axi_awready,

    // AXI4 write data
    output logic                   axi_wvalid,
    output logic [WORD_W-1:0]      axi_wdata,
    output logic [NBYTES-1:0]      axi_wstrb,
    output logic                   axi_wlast,
    input  logic                   axi_wready,

    // AXI4 write response
    input  logic                   axi_bvalid,
    input  logic [1:0]             axi_bresp,
    output logic                   axi_bready
);

    logic                   q_valid;
    logic [LINE_ADDR_W-1:0] q_addr;
    logic [LINE_W-1:0]      q_line;
    logic                   q_ready;   // pulse on OKAY, pops the head

    evict_queue u_evict_queue (
        .clk         (clk),
        .reset       (reset),
        .evict_valid (evict_valid),
        .evict_addr  (evict_addr),
        .evict_line  (evict_line),
        .evict_ready (evict_ready),
        .valid       (q_valid),
        .addr        (q_addr),
        .wdata       (q_line),
        .ready       (q_ready)
    );

    write_channel u_write_channel (
        .clk       (clk),
        .reset     (reset),
        .valid     (q_valid),
        .addr      (q_addr),
        .wdata     (q_line),
        .ready     (q_ready),
        .awvalid   (axi_awvalid),
        .awaddr    (axi_awaddr),
        .awlen     (axi_awlen),
        .awsize    (axi_awsize),
        .awburst   (axi_awburst),
        .awlock    (axi_awlock),
        .awcache   (axi_awcache),
        .awprot    (axi_awprot),
        .awqos     (axi_awqos),
        .awid      (axi_awid),
        .awready   (axi_awready),
        .wvalid    (axi_wvalid),
        .wdata_axi (axi_wdata),
        .wstrb     (axi_wstrb),
        .wlast     (axi_wlast),
        .wready    (axi_wready),
        .bvalid    (axi_bvalid),
        .bresp     (axi_bresp),
        .bready    (axi_bready)
    );

    // snoops the B channel on the bus side
    write_resp_monitor u_write_resp_monitor (
        .clk           (clk),
        .reset         (reset),
        .bvalid        (axi_bvalid),
        .bready        (axi_bready),
        .bresp         (axi_bresp),
        .line_done     (line_done),
        .lines_written (lines_written),
        .retry_count   (retry_count)
    );

endmodule

// ==== testbench/dcache_write_back_assertions.sv ====
`timescale 1ns/1ns

module dcache_write_back_assertions
    import dcache_wb_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic [WORD_W-1:0] wdata_axi,
    input logic              wlast,
    input logic              bready
);

    int fail_count = 0;

    logic [1:0] beat_cnt;   // W beats accepted in the current burst

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (awvalid && awready) begin
            beat_cnt <= '0;
        end else if (wvalid && wready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    aw_held: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid)
    else begin
        fail_count++;
        $error("awvalid dropped before awready");
    end

    // a stalled beat keeps its data
    w_stable: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata_axi))
    else begin
        fail_count++;
        $error("write beat changed while wready was low");
    end

    // response phase opens only once the last beat went out
    b_alone: assert property (@(posedge clk) disable iff (reset)
        $rose(bready) |-> $past(wvalid && wready && wlast))
    else begin
        fail_count++;
        $error("bready rose before the data phase finished");
    end

    last_valid: assert property (@(posedge clk) disable iff (reset)
        (wvalid || wlast) |-> wvalid && (wlast == (beat_cnt == 2'd3)))
    else begin
        fail_count++;
        $error("wlast not on the fourth valid beat");
    end

endmodule

bind write_channel dcache_write_back_assertions u_write_channel_assertions (
    .clk       (clk),
    .reset     (reset),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata_axi (wdata_axi),
    .wlast     (wlast),
    .bready    (bready)
);

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model
    import dcache_wb_pkg::*;
#(
    parameter int MEM_WORDS = 1024
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 axi_awvalid,
    input  logic [FE_ADDR_W-1:0] axi_awaddr,
    input  logic [7:0]           axi_awlen,
    input  logic [2:0]           axi_awsize,
    input  logic [1:0]           axi_awburst,
    input  logic [0:0]           axi_awlock,
    input  logic [3:0]           axi_awcache,
    input  logic [2:0]           axi_awprot,
    input  logic [3:0]           axi_awqos,
    input  logic [AXI_ID_W-1:0]  axi_awid,
    output logic                 axi_awready,
    input  logic                 axi_wvalid,
    input  logic [WORD_W-1:0]    axi_wdata,
    input  logic [NBYTES-1:0]    axi_wstrb,
    input  logic                 axi_wlast,
    output logic                 axi_wready,
    output logic                 axi_bvalid,
    output logic [1:0]           axi_bresp,
    input  logic                 axi_bready
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [WORD_W-1:0]    mem [MEM_WORDS];
    logic [FE_ADDR_W-1:0] err_addr [64];
    int                   err_left [64];
    int                   err_entries = 0;
    logic [FE_ADDR_W-1:0] okay_log [64];
    int                   okay_cnt = 0;
    int                   errors = 0;

    logic [31:0]          rng = 32'h2cf2955c;
    logic [FE_ADDR_W-1:0] base;
    logic [1:0]           beat;
    logic [IDX_W-1:0]     idx;
    logic [1:0]           resp;
    logic                 aw_taken;
    logic                 b_pending;

    initial begin
        axi_awready = 1'b0;
        axi_wready  = 1'b0;
        axi_bvalid  = 1'b0;
        axi_bresp   = 2'b00;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hdead_0000 ^ i;   // unwritten words stand out
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_errors(input logic [FE_ADDR_W-1:0] a, input int n);
        err_addr[err_entries] = a;
        err_left[err_entries] = n;
        err_entries++;
    endtask

    // SLVERR while the address still has injected errors left
    task automatic pick_response(output logic [1:0] r);
        r = 2'b00;
        for (int k = 0; k < err_entries; k++) begin
            if (r == 2'b00 && err_addr[k] == base && err_left[k] > 0) begin
                err_left[k]--;
                r = 2'b10;
            end
        end
    endtask

    // everything moves on the falling edge; a handshake decided here
    // completes on the next rising edge
    always @(negedge clk or posedge reset) begin
        if (reset) begin
            axi_awready = 1'b0;
            axi_wready  = 1'b0;
            axi_bvalid  = 1'b0;
            axi_bresp   = 2'b00;
            aw_taken    = 1'b0;
            b_pending   = 1'b0;
            beat        = '0;
            base        = '0;
        end else begin
            rng = xorshift(rng);
            axi_awready = 1'b0;
            if (axi_awvalid && !aw_taken) begin
                axi_awready = (rng[1:0] != 2'b00);
                if (axi_awready) begin
                    assert (axi_awlen == 8'd3 && axi_awsize == 3'd2 && axi_awburst == 2'b01)
                    else begin
                        errors++;
                        $display("MISMATCH %0t: burst len %0d size %0d type %0d, expected 3 2 1",
                                 $time, axi_awlen, axi_awsize, axi_awburst);
                    end
                    // plain normal access, cacheable and bufferable, id 0
                    assert (axi_awlock == 1'b0 && axi_awcache == 4'd3 && axi_awprot == 3'd0
                            && axi_awqos == 4'd0 && axi_awid == '0)
                    else begin
                        errors++;
                        $display("MISMATCH %0t: lock %0d cache %0d prot %0d qos %0d id %0d, %s",
                                 $time, axi_awlock, axi_awcache, axi_awprot, axi_awqos,
                                 axi_awid, "expected 0 3 0 0 0");
                    end
                    base     = axi_awaddr;
                    beat     = '0;
                    aw_taken = 1'b1;
                end
            end
            axi_wready = 1'b0;
            if (axi_wvalid && aw_taken && !b_pending) begin
                axi_wready = (rng[3:2] != 2'b00);
                if (axi_wready) begin
                    assert (axi_wstrb == 4'hf && axi_wlast == (beat == 2'd3))
                    else begin
                        errors++;
                        $display("MISMATCH %0t: beat %0d has wstrb %h wlast %b", $time,
                                 beat, axi_wstrb, axi_wlast);
                    end
                    idx      = base[IDX_W+1:2] + IDX_W'(beat);
                    mem[idx] = axi_wdata;
                    if (beat == 2'd3) begin
                        b_pending = 1'b1;
                    end else begin
                        beat = beat + 1'b1;
                    end
                end
            end
            axi_bvalid = 1'b0;
            if (b_pending && axi_bready) begin
                pick_response(resp);
                axi_bvalid = 1'b1;
                axi_bresp  = resp;
                if (resp == 2'b00) begin
                    okay_log[okay_cnt] = base;
                    okay_cnt++;
                end
                b_pending = 1'b0;
                aw_taken  = 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_dcache_write_back.sv ====
`timescale 1ns/1ns

module tb_dcache_write_back
    import dcache_wb_pkg::*;
();

    localparam int MAX_LINES = 32;
    localparam int MEM_WORDS = 1024;

    logic                   clk;
    logic                   reset;
    logic                   evict_valid;
    logic [LINE_ADDR_W-1:0] evict_addr;
    logic [LINE_W-1:0]      evict_line;
    logic                   evict_ready;
    logic                   line_done;
    logic [CNT_W-1:0]       lines_written;
    logic [CNT_W-1:0]       retry_count;

    logic                   axi_awvalid;
    logic [FE_ADDR_W-1:0]   axi_awaddr;
    logic [7:0]             axi_awlen;
    logic [2:0]             axi_awsize;
    logic [1:0]             axi_awburst;
    logic [0:0]             axi_awlock;
    logic [3:0]             axi_awcache;
    logic [2:0]             axi_awprot;
    logic [3:0]             axi_awqos;
    logic [AXI_ID_W-1:0]    axi_awid;
    logic                   axi_awready;
    logic                   axi_wvalid;
    logic [WORD_W-1:0]      axi_wdata;
    logic [NBYTES-1:0]      axi_wstrb;
    logic                   axi_wlast;
    logic                   axi_wready;
    logic                   axi_bvalid;
    logic [1:0]             axi_bresp;
    logic                   axi_bready;

    // golden lines and the memory image they should leave behind
    logic [LINE_ADDR_W-1:0] g_addr [MAX_LINES];
    logic [WORD_W-1:0]      g_word [MAX_LINES][4];
    int                     g_err [MAX_LINES];
    logic [WORD_W-1:0]      exp_mem [MEM_WORDS];

    int   n_lines = 0;
    int   total_err = 0;
    int   errors = 0;
    int   done_cnt = 0;
    int   budget = 200;
    int   total;
    logic budget_ready = 1'b0;
    logic saw_full = 1'b0;

    dcache_write_back u_dcache_write_back (.*);

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) u_axi_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outputs only move on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!reset) begin
            if (line_done) begin
                done_cnt++;
            end
            if (!evict_ready) begin
                saw_full = 1'b1;   // back-pressure reached the cache side
            end
        end
    end

    task automatic load_golden();
        int          fd;
        int          r;
        string       text;
        logic [31:0] a;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        int          e;
        fd = $fopen("testbench/golden_writes.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the golden file testbench/golden_writes.txt");
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(text, fd);
                if (r > 0) begin
                    // comment and blank lines do not parse to six fields
                    r = $sscanf(text, "%h %h %h %h %h %d", a, w0, w1, w2, w3, e);
                    if (r == 6 && (a >= MEM_WORDS / 4 || n_lines == MAX_LINES)) begin
                        errors++;
                        $display("golden line for address %h is outside what the test holds", a);
                    end else if (r == 6) begin
                        g_addr[n_lines]    = a[LINE_ADDR_W-1:0];
                        g_word[n_lines][0] = w0;
                        g_word[n_lines][1] = w1;
                        g_word[n_lines][2] = w2;
                        g_word[n_lines][3] = w3;
                        g_err[n_lines]     = e;
                        for (int j = 0; j < 4; j++) begin
                            exp_mem[int'(a) * 4 + j] = g_word[n_lines][j];
                        end
                        total_err += e;
                        budget += (4 + e + 1) * 40;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reset_values();
        assert (!axi_awvalid && !axi_wvalid && !axi_bready && !line_done)
        else begin
            errors++;
            $display("MISMATCH %0t: a handshake output is high after reset", $time);
        end
        assert (evict_ready)
        else begin
            errors++;
            $display("MISMATCH %0t: evict_ready is low with an empty queue", $time);
        end
        assert (lines_written == 0 && retry_count == 0)
        else begin
            errors++;
            $display("MISMATCH %0t: counters are %0d and %0d after reset, expected 0",
                     $time, lines_written, retry_count);
        end
    endtask

    // one line per cycle as long as the queue takes them
    task automatic push_lines();
        for (int i = 0; i < n_lines; i++) begin
            @(negedge clk);
            evict_valid = 1'b1;
            evict_addr  = g_addr[i];
            evict_line  = {g_word[i][3], g_word[i][2], g_word[i][1], g_word[i][0]};
            while (!evict_ready) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        evict_valid = 1'b0;
    endtask

    task automatic check_results();
        int idx;
        for (int i = 0; i < n_lines; i++) begin
            for (int j = 0; j < 4; j++) begin
                idx = int'(g_addr[i]) * 4 + j;
                assert (u_axi_mem_model.mem[idx] === exp_mem[idx])
                else begin
                    errors++;
                    $display("MISMATCH %0t: line %h word %0d holds %h, expected %h", $time,
                             g_addr[i], j, u_axi_mem_model.mem[idx], exp_mem[idx]);
                end
            end
        end
        assert (u_axi_mem_model.okay_cnt == n_lines)
        else begin
            errors++;
            $display("MISMATCH %0t: %0d OKAY responses, expected %0d", $time,
                     u_axi_mem_model.okay_cnt, n_lines);
        end
        for (int k = 0; k < n_lines && k < u_axi_mem_model.okay_cnt; k++) begin
            assert (u_axi_mem_model.okay_log[k] == {g_addr[k], 4'b0000})
            else begin
                errors++;
                $display("MISMATCH %0t: completion %0d was address %h, expected %h", $time,
                         k, u_axi_mem_model.okay_log[k], {g_addr[k], 4'b0000});
            end
        end
        assert (done_cnt == n_lines && lines_written == n_lines)
        else begin
            errors++;
            $display("MISMATCH %0t: %0d line_done pulses, lines_written %0d, expected %0d",
                     $time, done_cnt, lines_written, n_lines);
        end
        assert (retry_count == total_err)
        else begin
            errors++;
            $display("MISMATCH %0t: retry_count %0d, expected %0d", $time,
                     retry_count, total_err);
        end
        assert (saw_full || n_lines < QUEUE_DEPTH)
        else begin
            errors++;
            $display("evict_ready never went low while lines were pushed back to back");
        end
    endtask

    initial begin
        reset       = 1'b1;
        evict_valid = 1'b0;
        evict_addr  = '0;
        evict_line  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_reset_values();
        load_golden();
        for (int i = 0; i < n_lines; i++) begin
            u_axi_mem_model.add_errors({g_addr[i], 4'b0000}, g_err[i]);
        end
        budget_ready = 1'b1;
        push_lines();
        wait (done_cnt == n_lines);
        repeat (10) @(negedge clk);   // room for a stray extra pulse
        check_results();
        total = errors + u_axi_mem_model.errors
              + u_dcache_write_back.u_write_channel.u_write_channel_assertions.fail_count;
        $display("error count: %0d testbench, %0d memory model, %0d protocol", errors,
                 u_axi_mem_model.errors,
                 u_dcache_write_back.u_write_channel.u_write_channel_assertions.fail_count);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // budget grows with the lines and their injected errors
    initial begin
        wait (budget_ready);
        repeat (budget) @(posedge clk);
        $display("timeout: %0d lines were not written back within %0d cycles", n_lines, budget);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== testbench/golden_writes.txt ====
# line_addr(hex, 28 bit)  word0  word1  word2  word3 (hex)  slverr_count(decimal)
# each line is one evicted line, written to byte address line_addr * 16
0000010 a0000000 a0000001 a0000002 a0000003 0
0000011 b1b2b3b4 c1c2c3c4 d1d2d3d4 e1e2e3e4 0
0000012 00000000 ffffffff 55555555 aaaaaaaa 0
0000013 12345678 9abcdef0 0fedcba9 87654321 1
0000014 deadbeef cafef00d 0badc0de 8badf00d 0
0000015 00000001 00000002 00000004 00000008 0
0000020 13579bdf 2468ace0 fdb97531 0eca8642 0
0000021 11111111 22222222 33333333 44444444 2
0000022 5a5a5a5a a5a5a5a5 3c3c3c3c c3c3c3c3 0
0000023 01020304 05060708 090a0b0c 0d0e0f10 0
000003f 7fffffff 80000000 7ffffffe 80000001 0
0000040 f0f0f0f0 0f0f0f0f ff00ff00 00ff00ff 0
0000041 c0ffee00 c0ffee01 c0ffee02 c0ffee03 1
0000042 abcdef01 bcdef012 cdef0123 def01234 0
0000050 76543210 fedcba98 01234567 89abcdef 0
0000051 10101010 20202020 30303030 40404040 0
0000080 aaaa0000 bbbb1111 cccc2222 dddd3333 0
0000081 99999999 88888888 77777777 66666666 0
00000fe 00c0ffee 00beef00 00f00d00 00abcd00 3
00000ff e0e1e2e3 f0f1f2f3 a0a1a2a3 b0b1b2b3 0
0000001 fedcba98 76543210 00000000 11111111 0
0000002 31415926 27182818 16180339 14142135 0

// ==== sources.f ====
src/dcache_wb_pkg.sv
src/evict_queue.sv
src/write_channel.sv
src/write_resp_monitor.sv
src/dcache_write_back.sv
testbench/dcache_write_back_assertions.sv
testbench/axi_mem_model.sv
testbench/tb_dcache_write_back.sv

// ==== Bender.yml ====
package:
  name: dcache_write_back

sources:
  - files:
      - src/dcache_wb_pkg.sv
      - src/evict_queue.sv
      - src/write_channel.sv
      - src/write_resp_monitor.sv
      - src/dcache_write_back.sv

  - target: test
    files:
      - testbench/dcache_write_back_assertions.sv
      - testbench/axi_mem_model.sv
      - testbench/tb_dcache_write_back.sv
